// File: hdl/ahbPkg.sv
package ahbPkg;

    // Memory map
    localparam int numSlaves    = 4;
    localparam int ramAddrWidth = 10;
    localparam int regionShift  = 12;

    // Bus field types
    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;
    typedef logic [1:0]  transT;
    typedef logic [2:0]  sizeT;

    // One bit per RAM slave
    typedef logic [numSlaves-1:0] slaveSelT;

    // HTRANS encodings
    localparam transT transIdle   = 2'b00;
    localparam transT transBusy   = 2'b01;
    localparam transT transNonseq = 2'b10;
    localparam transT transSeq    = 2'b11;

    // HSIZE encodings
    localparam sizeT sizeByte = 3'b000;
    localparam sizeT sizeHalf = 3'b001;
    localparam sizeT sizeWord = 3'b010;

    // HRESP encodings
    localparam logic respOkay  = 1'b0;
    localparam logic respError = 1'b1;

    // Default slave response sequence
    typedef enum logic [1:0] {
        errIdle,
        errFirst,
        errSecond
    } errStateT;

endpackage

// File: hdl/ahbSlaveIf.sv
`timescale 1ns/100ps

interface ahbSlaveIf;

    // Address phase, from the decoder
    logic                hsel;
    ahbPkg::addrT        haddr;
    ahbPkg::sizeT        hsize;
    ahbPkg::transT       htrans;
    ahbPkg::dataT        hwdata;
    logic                hwrite;

    // Shared bus ready, from the mux
    logic                hready;

    // Slave response
    ahbPkg::dataT        hrdata;
    logic                hreadyout;
    logic                hresp;

    modport decoderSide (
        output hsel, haddr, hsize, htrans, hwdata, hwrite
    );

    modport slaveSide (
        input  hsel, haddr, hsize, htrans, hwdata, hwrite, hready,
        output hrdata, hreadyout, hresp
    );

    modport muxSide (
        output hready,
        input  hsel, hrdata, hreadyout, hresp
    );

endinterface

// File: hdl/AHBLiteDecoder.sv
`timescale 1ns/100ps

module AHBLiteDecoder
(
    input  ahbPkg::addrT   HADDR,
    input  ahbPkg::sizeT   HSIZE,
    input  ahbPkg::transT  HTRANS,
    input  ahbPkg::dataT   HWDATA,
    input  logic           HWRITE,
    output logic           unmapped,
    ahbSlaveIf.decoderSide slaves [ahbPkg::numSlaves]
);

    ahbPkg::slaveSelT hit;

    generate
        for (genvar i = 0; i < ahbPkg::numSlaves; i++) begin : gSlave
            // Region i spans i*4KB up to the next region
            assign hit[i] = (HADDR >> ahbPkg::regionShift) == ahbPkg::addrT'(i);

            assign slaves[i].hsel   = hit[i];
            assign slaves[i].haddr  = HADDR;
            assign slaves[i].hsize  = HSIZE;
            assign slaves[i].htrans = HTRANS;
            assign slaves[i].hwdata = HWDATA;
            assign slaves[i].hwrite = HWRITE;
        end
    endgenerate

    // Nothing claims the address, so the mux answers as default slave
    assign unmapped = ~|hit;

endmodule

// File: hdl/AHBLiteBlockRAM.sv
`timescale 1ns/100ps

module AHBLiteBlockRAM
(
    input  logic         HCLK,
    input  logic         rstN,
    ahbSlaveIf.slaveSide bus
);

    typedef logic [ahbPkg::ramAddrWidth-1:0] wordAddrT;

    ahbPkg::dataT mem [2**ahbPkg::ramAddrWidth];

    logic         active;
    logic         accept;
    wordAddrT     addrWord;
    logic [3:0]   laneMask;

    // Write waiting for its data phase
    logic         wrPending;
    wordAddrT     wrAddr;
    logic [3:0]   wrMask;

    // Read path
    ahbPkg::dataT rdWord;
    ahbPkg::dataT fwdData;
    logic [3:0]   fwdMask;
    ahbPkg::dataT rdMerged;

    // Little-endian byte lanes touched by a transfer
    function automatic logic [3:0] byteMask(
        input ahbPkg::sizeT size,
        input logic [1:0]   offset
    );
        logic [3:0] mask;
        case (size)
            ahbPkg::sizeByte: mask = 4'b0001 << offset;
            ahbPkg::sizeHalf: mask = 4'b0011 << {offset[1], 1'b0};
            ahbPkg::sizeWord: mask = 4'b1111;
            default:          mask = 4'b1111;
        endcase
        return mask;
    endfunction

    assign active   = (bus.htrans == ahbPkg::transNonseq) ||
                      (bus.htrans == ahbPkg::transSeq);
    assign accept   = bus.hsel && active && bus.hready;
    assign addrWord = bus.haddr[ahbPkg::ramAddrWidth+1:2];
    assign laneMask = byteMask(bus.hsize, bus.haddr[1:0]);

    // Control state holds while hready is low
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            wrPending <= 1'b0;
            fwdMask   <= 4'b0000;
        end else if (bus.hready) begin
            wrPending <= accept && bus.hwrite;
            if (accept && !bus.hwrite) begin
                // Write to the same word lands on this edge
                fwdMask <= (wrPending && wrAddr == addrWord) ? wrMask : 4'b0000;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept && bus.hwrite) begin
            wrAddr <= addrWord;
            wrMask <= laneMask;
        end
        if (accept && !bus.hwrite) begin
            fwdData <= bus.hwdata;
        end
    end

    // Byte-lane writes in the data phase, synchronous read in the address phase
    always_ff @(posedge HCLK) begin
        if (wrPending && bus.hready) begin
            for (int b = 0; b < 4; b++) begin
                if (wrMask[b]) begin
                    mem[wrAddr][8*b +: 8] <= bus.hwdata[8*b +: 8];
                end
            end
        end
        if (accept && !bus.hwrite) begin
            rdWord <= mem[addrWord];
        end
    end

    // Forwarded bytes over the stored word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rdMerged[8*b +: 8] = fwdMask[b] ? fwdData[8*b +: 8] : rdWord[8*b +: 8];
        end
    end

    assign bus.hrdata    = rdMerged;
    assign bus.hreadyout = 1'b1;
    assign bus.hresp     = ahbPkg::respOkay;

endmodule

// File: hdl/AHBLiteSlaveMux.sv
`timescale 1ns/100ps

module AHBLiteSlaveMux
(
    input  logic          HCLK,
    input  logic          rstN,
    input  ahbPkg::transT HTRANS,
    input  logic          unmapped,
    output logic          HREADY,
    output logic          HRESP,
    output ahbPkg::dataT  HRDATA,
    ahbSlaveIf.muxSide    bus [ahbPkg::numSlaves]
);

    ahbPkg::slaveSelT              selVec;
    ahbPkg::slaveSelT              owner;
    logic [ahbPkg::numSlaves-1:0]  readyVec;
    logic [ahbPkg::numSlaves-1:0]  respVec;
    ahbPkg::dataT                  rdataVec [ahbPkg::numSlaves];

    ahbPkg::errStateT errState;
    logic             active;
    logic             slaveReady;
    logic             slaveResp;

    generate
        for (genvar i = 0; i < ahbPkg::numSlaves; i++) begin : gBus
            assign selVec[i]   = bus[i].hsel;
            assign readyVec[i] = bus[i].hreadyout;
            assign respVec[i]  = bus[i].hresp;
            assign rdataVec[i] = bus[i].hrdata;
            assign bus[i].hready = HREADY;
        end
    endgenerate

    assign active = !((HTRANS == ahbPkg::transIdle) || (HTRANS == ahbPkg::transBusy));

    // Data-phase owner, empty for idle or unmapped transfers
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            owner <= '0;
        end else if (HREADY) begin
            owner <= active ? selVec : '0;
        end
    end

    // Default slave, two-cycle ERROR response
    always_ff @(posedge HCLK) begin
        if (!rstN) begin
            errState <= ahbPkg::errIdle;
        end else begin
            case (errState)
                ahbPkg::errIdle: begin
                    if (HREADY && active && unmapped) begin
                        errState <= ahbPkg::errFirst;
                    end
                end
                ahbPkg::errFirst: begin
                    errState <= ahbPkg::errSecond;
                end
                ahbPkg::errSecond: begin
                    // HREADY is high here, so a new address phase is taken
                    errState <= (active && unmapped) ? ahbPkg::errFirst : ahbPkg::errIdle;
                end
                default: begin
                    errState <= ahbPkg::errIdle;
                end
            endcase
        end
    end

    // Owner response, zero data when nobody owns the data phase
    always_comb begin
        slaveReady = 1'b1;
        slaveResp  = ahbPkg::respOkay;
        HRDATA     = '0;
        for (int i = 0; i < ahbPkg::numSlaves; i++) begin
            if (owner[i]) begin
                slaveReady = readyVec[i];
                slaveResp  = respVec[i];
                HRDATA     = rdataVec[i];
            end
        end
    end

    always_comb begin
        case (errState)
            ahbPkg::errFirst: begin
                HREADY = 1'b0;
                HRESP  = ahbPkg::respError;
            end
            ahbPkg::errSecond: begin
                HREADY = 1'b1;
                HRESP  = ahbPkg::respError;
            end
            default: begin
                HREADY = slaveReady;
                HRESP  = slaveResp;
            end
        endcase
    end

endmodule

// File: hdl/AHBLiteMemSystem.sv
`timescale 1ns/100ps

module AHBLiteMemSystem
(
    input  logic          HCLK,
    input  logic          rstN,
    input  ahbPkg::addrT  HADDR,
    input  ahbPkg::sizeT  HSIZE,
    input  ahbPkg::transT HTRANS,
    input  ahbPkg::dataT  HWDATA,
    input  logic          HWRITE,
    output logic          HREADY,
    output ahbPkg::dataT  HRDATA,
    output logic          HRESP
);

    logic unmapped;

    // One bus per RAM slave
    ahbSlaveIf slaveBus [ahbPkg::numSlaves] ();

    // Decoder
    AHBLiteDecoder uDecoder
    (
        .HADDR(HADDR),
        .HSIZE(HSIZE),
        .HTRANS(HTRANS),
        .HWDATA(HWDATA),
        .HWRITE(HWRITE),
        .unmapped(unmapped),
        .slaves(slaveBus)
    );

    // RAM slaves, 4KB each
    generate
        for (genvar i = 0; i < ahbPkg::numSlaves; i++) begin : gRam
            AHBLiteBlockRAM uRam
            (
                .HCLK(HCLK),
                .rstN(rstN),
                .bus(slaveBus[i])
            );
        end
    endgenerate

    // Slave mux and default slave
    AHBLiteSlaveMux uSlaveMux
    (
        .HCLK(HCLK),
        .rstN(rstN),
        .HTRANS(HTRANS),
        .unmapped(unmapped),
        .HREADY(HREADY),
        .HRESP(HRESP),
        .HRDATA(HRDATA),
        .bus(slaveBus)
    );

endmodule

// File: test/AHBLiteMemSystem_asserts.sv
`timescale 1ns/100ps

module AHBLiteMemSystem_asserts
(
    input logic          HCLK,
    input logic          rstN,
    input ahbPkg::addrT  HADDR,
    input ahbPkg::transT HTRANS,
    input logic          HREADY,
    input logic          HRESP
);

    int   failCount = 0;
    logic addrPhase;
    logic unmappedPhase;

    assign addrPhase     = HREADY && ((HTRANS == ahbPkg::transNonseq) ||
                                      (HTRANS == ahbPkg::transSeq));
    assign unmappedPhase = addrPhase && (HADDR[31:14] != 18'd0);

    // First cycle out of reset
    resetState: assert property (@(posedge HCLK) $rose(rstN) |-> HREADY && !HRESP)
        else begin
            failCount++;
            $error("bus not ready with OKAY response after reset");
        end

    // Two-cycle ERROR response
    errorSecond: assert property (@(posedge HCLK) disable iff (!rstN)
        HRESP && !HREADY |=> HRESP && HREADY)
        else begin
            failCount++;
            $error("ERROR response did not finish with HREADY high");
        end

    stallLength: assert property (@(posedge HCLK) disable iff (!rstN)
        !HREADY |=> HREADY)
        else begin
            failCount++;
            $error("HREADY low for more than one cycle");
        end

    respCause: assert property (@(posedge HCLK) disable iff (!rstN)
        $rose(HRESP) |-> $past(unmappedPhase))
        else begin
            failCount++;
            $error("HRESP raised without an unmapped address phase");
        end

endmodule

bind AHBLiteMemSystem AHBLiteMemSystem_asserts memAsserts (
    .HCLK(HCLK),
    .rstN(rstN),
    .HADDR(HADDR),
    .HTRANS(HTRANS),
    .HREADY(HREADY),
    .HRESP(HRESP)
);

// File: test/tbMemSystem.sv
`timescale 1ns/100ps

module tbMemSystem;

    localparam int clkPeriod    = 40;
    localparam int resetIdle    = 4;
    localparam int wordsPerSlave = 4;
    localparam int laneTests    = 8;
    localparam int b2bTests     = 8;
    localparam int errTests     = 4;
    localparam int idleTests    = 8;
    // Plus one idle transfer that drains the last data phase
    localparam int numTransfers = resetIdle + 2 * wordsPerSlave * ahbPkg::numSlaves
                                + 4 * laneTests + 4 * b2bTests + 3 * errTests
                                + 2 * idleTests + 1;

    logic          HCLK;
    logic          rstN;
    ahbPkg::addrT  HADDR;
    ahbPkg::sizeT  HSIZE;
    ahbPkg::transT HTRANS;
    ahbPkg::dataT  HWDATA;
    logic          HWRITE;
    logic          HREADY;
    ahbPkg::dataT  HRDATA;
    logic          HRESP;

    integer seed;
    int     errors;

    // Word image of the 16 KB mapped space
    ahbPkg::dataT refMem [4096];
    ahbPkg::addrT written [$];
    ahbPkg::addrT idleAddr [idleTests];

    // Transfer currently in its data phase
    logic         dpValid;
    logic         dpWrite;
    logic         dpErr;
    logic         errSeen;
    ahbPkg::dataT dpWdata;
    ahbPkg::dataT dpExpect;

    AHBLiteMemSystem dut0 (
        .HCLK(HCLK),
        .rstN(rstN),
        .HADDR(HADDR),
        .HSIZE(HSIZE),
        .HTRANS(HTRANS),
        .HWDATA(HWDATA),
        .HWRITE(HWRITE),
        .HREADY(HREADY),
        .HRDATA(HRDATA),
        .HRESP(HRESP)
    );

    initial begin
        HCLK = 1'b0;
        forever #(clkPeriod / 2) HCLK = ~HCLK;
    end

    initial begin
        #((numTransfers * 3 + 100) * clkPeriod);
        $display("Timeout: the bus stopped completing transfers");
        $display("TB FAILED");
        $finish;
    end

    // New word after writing the addressed little-endian lanes
    function automatic ahbPkg::dataT mergeLanes(
        input ahbPkg::dataT oldWord,
        input ahbPkg::dataT wdata,
        input ahbPkg::sizeT size,
        input logic [1:0]   offset
    );
        ahbPkg::dataT result;
        int first;
        int count;
        result = oldWord;
        if (size == ahbPkg::sizeWord) begin
            first = 0;
            count = 4;
        end else if (size == ahbPkg::sizeHalf) begin
            first = int'({offset[1], 1'b0});
            count = 2;
        end else begin
            first = int'(offset);
            count = 1;
        end
        for (int b = first; b < first + count; b++) begin
            result[8*b +: 8] = wdata[8*b +: 8];
        end
        return result;
    endfunction

    function automatic ahbPkg::addrT randomAddr();
        return ahbPkg::addrT'($random(seed)) & 32'h0000_3ffc;
    endfunction

    task automatic checkValue(input string name, input ahbPkg::dataT expected,
                              input ahbPkg::dataT actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Outputs are stable at the falling edge
    task automatic checkDataPhase();
        if (dpValid && dpErr) begin
            checkValue("HRESP", 32'd1, ahbPkg::dataT'(HRESP));
            checkValue("HREADY", errSeen ? 32'd1 : 32'd0, ahbPkg::dataT'(HREADY));
            errSeen = 1'b1;
        end else begin
            checkValue("HREADY", 32'd1, ahbPkg::dataT'(HREADY));
            checkValue("HRESP", 32'd0, ahbPkg::dataT'(HRESP));
            if (!dpValid) begin
                checkValue("HRDATA", 32'd0, HRDATA);
            end else if (!dpWrite) begin
                checkValue("HRDATA", dpExpect, HRDATA);
            end
        end
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic transfer(input ahbPkg::addrT addr, input ahbPkg::sizeT size,
                            input ahbPkg::transT trans, input logic write,
                            input ahbPkg::dataT wdata);
        logic accepted;
        logic active;
        logic mapped;
        active   = (trans == ahbPkg::transNonseq) || (trans == ahbPkg::transSeq);
        mapped   = addr < 32'h0000_4000;
        accepted = 1'b0;
        HADDR  = addr;
        HSIZE  = size;
        HTRANS = trans;
        HWRITE = write;
        HWDATA = (dpValid && dpWrite) ? dpWdata : ahbPkg::dataT'($random(seed));
        while (!accepted) begin
            checkDataPhase();
            accepted = HREADY;
            @(negedge HCLK);
        end
        dpValid = active;
        dpWrite = write;
        dpErr   = active && !mapped;
        errSeen = 1'b0;
        dpWdata = wdata;
        if (active && mapped) begin
            if (write) begin
                refMem[addr[13:2]] = mergeLanes(refMem[addr[13:2]], wdata, size, addr[1:0]);
            end else begin
                dpExpect = refMem[addr[13:2]];
            end
        end
    endtask

    task automatic writeWord(input ahbPkg::addrT addr, input ahbPkg::dataT data);
        transfer(addr, ahbPkg::sizeWord, ahbPkg::transNonseq, 1'b1, data);
    endtask

    task automatic readWord(input ahbPkg::addrT addr);
        transfer(addr, ahbPkg::sizeWord, ahbPkg::transNonseq, 1'b0, 32'd0);
    endtask

    task automatic idleCycle(input logic write, input ahbPkg::addrT addr);
        transfer(addr, ahbPkg::sizeWord, ahbPkg::transIdle, write, ahbPkg::dataT'($random(seed)));
    endtask

    initial begin
        ahbPkg::addrT addr;
        ahbPkg::addrT bad;
        seed     = 38473;
        errors   = 0;
        rstN     = 1'b0;
        HADDR    = 32'd0;
        HSIZE    = ahbPkg::sizeWord;
        HTRANS   = ahbPkg::transIdle;
        HWDATA   = 32'd0;
        HWRITE   = 1'b0;
        dpValid  = 1'b0;
        dpWrite  = 1'b0;
        dpErr    = 1'b0;
        errSeen  = 1'b0;
        dpWdata  = 32'd0;
        dpExpect = 32'd0;
        repeat (2) @(posedge HCLK);
        @(negedge HCLK);
        rstN = 1'b1;

        // Reset state with the bus idle
        repeat (resetIdle) idleCycle(1'b0, 32'd0);

        // Word access in every slave
        for (int s = 0; s < ahbPkg::numSlaves; s++) begin
            for (int k = 0; k < wordsPerSlave; k++) begin
                addr = (ahbPkg::addrT'(s) << 12) | (randomAddr() & 32'h0000_0ffc);
                written.push_back(addr);
                writeWord(addr, ahbPkg::dataT'($random(seed)));
            end
        end
        foreach (written[i]) readWord(written[i]);

        // Byte and halfword lanes
        for (int i = 0; i < laneTests; i++) begin
            addr = randomAddr();
            written.push_back(addr);
            writeWord(addr, ahbPkg::dataT'($random(seed)));
            transfer(addr | (ahbPkg::addrT'($random(seed)) & 32'd3), ahbPkg::sizeByte,
                     ahbPkg::transNonseq, 1'b1, ahbPkg::dataT'($random(seed)));
            transfer(addr | (ahbPkg::addrT'($random(seed)) & 32'd2), ahbPkg::sizeHalf,
                     ahbPkg::transNonseq, 1'b1, ahbPkg::dataT'($random(seed)));
            readWord(addr);
        end

        // Read straight after a write to the same word
        for (int i = 0; i < b2bTests; i++) begin
            addr = randomAddr();
            written.push_back(addr);
            writeWord(addr, ahbPkg::dataT'($random(seed)));
            readWord(addr);
            transfer(addr | (ahbPkg::addrT'($random(seed)) & 32'd3), ahbPkg::sizeByte,
                     ahbPkg::transNonseq, 1'b1, ahbPkg::dataT'($random(seed)));
            readWord(addr);
        end

        // Unmapped accesses alias onto a written word
        for (int i = 0; i < errTests; i++) begin
            addr = written[$unsigned($random(seed)) % written.size()];
            bad  = addr | ((ahbPkg::addrT'($random(seed)) | 32'd1) << 14);
            readWord(bad);
            writeWord(bad, ahbPkg::dataT'($random(seed)));
            readWord(addr);
        end

        // IDLE with HWRITE high must not write
        for (int i = 0; i < idleTests; i++) begin
            idleAddr[i] = written[$unsigned($random(seed)) % written.size()];
            idleCycle(1'b1, idleAddr[i]);
        end
        foreach (idleAddr[i]) readWord(idleAddr[i]);

        idleCycle(1'b0, 32'd0);

        $display("Errors: %0d data checks, %0d assertion failures",
                 errors, dut0.memAsserts.failCount);
        if (errors == 0 && dut0.memAsserts.failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/ahbPkg.sv
hdl/ahbSlaveIf.sv
hdl/AHBLiteDecoder.sv
hdl/AHBLiteBlockRAM.sv
hdl/AHBLiteSlaveMux.sv
hdl/AHBLiteMemSystem.sv
test/AHBLiteMemSystem_asserts.sv
test/tbMemSystem.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tbMemSystem
FLIST     := flist.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
